// ==== source/proc_pkg.sv ====
// ---------------------------------------------------------
// Reduced PISA encodings for the four-stage core
// No loads, stores, jumps, multiply or variable shifts
// ---------------------------------------------------------
`default_nettype none

package proc_pkg;

  localparam int xlen     = 32;
  localparam int reg_bits = 5;

  // Primary opcodes
  localparam logic [5:0] op_special = 6'b000000;
  localparam logic [5:0] op_beq     = 6'b000100;
  localparam logic [5:0] op_bne     = 6'b000101;
  localparam logic [5:0] op_addiu   = 6'b001001;
  localparam logic [5:0] op_slti    = 6'b001010;
  localparam logic [5:0] op_sltiu   = 6'b001011;
  localparam logic [5:0] op_andi    = 6'b001100;
  localparam logic [5:0] op_ori     = 6'b001101;
  localparam logic [5:0] op_xori    = 6'b001110;
  localparam logic [5:0] op_lui     = 6'b001111;
  localparam logic [5:0] op_cop0    = 6'b010000;

  // Function field of the special opcode
  localparam logic [5:0] fn_sll  = 6'b000000;
  localparam logic [5:0] fn_srl  = 6'b000010;
  localparam logic [5:0] fn_sra  = 6'b000011;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_xor  = 6'b100110;
  localparam logic [5:0] fn_nor  = 6'b100111;
  localparam logic [5:0] fn_slt  = 6'b101010;
  localparam logic [5:0] fn_sltu = 6'b101011;

  // Cop0 direction lives in the rs field
  localparam logic [reg_bits-1:0] cop0_mf = 5'b00000;
  localparam logic [reg_bits-1:0] cop0_mt = 5'b00100;

  // ALU functions
  localparam logic [3:0] alu_add = 4'd0;
  localparam logic [3:0] alu_sub = 4'd1;
  localparam logic [3:0] alu_and = 4'd2;
  localparam logic [3:0] alu_or  = 4'd3;
  localparam logic [3:0] alu_xor = 4'd4;
  localparam logic [3:0] alu_nor = 4'd5;
  localparam logic [3:0] alu_lts = 4'd6;
  localparam logic [3:0] alu_ltu = 4'd7;
  localparam logic [3:0] alu_sll = 4'd8;
  localparam logic [3:0] alu_srl = 4'd9;
  localparam logic [3:0] alu_sra = 4'd10;
  localparam logic [3:0] alu_lui = 4'd11;
  localparam logic [3:0] alu_cp1 = 4'd12; // Pass operand B

  // Operand B select
  localparam logic [1:0] bm_reg  = 2'd0;
  localparam logic [1:0] bm_si   = 2'd1;
  localparam logic [1:0] bm_zi   = 2'd2;
  localparam logic [1:0] bm_mngr = 2'd3;

  // Branch types
  localparam logic [1:0] br_none = 2'd0;
  localparam logic [1:0] br_eq   = 2'd1;
  localparam logic [1:0] br_ne   = 2'd2;

  // One instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [5:0]          opcode;
      logic [reg_bits-1:0] rs;
      logic [reg_bits-1:0] rt;
      logic [reg_bits-1:0] rd;
      logic [reg_bits-1:0] shamt;
      logic [5:0]          func;
    } r;
    struct packed {
      logic [5:0]          opcode;
      logic [reg_bits-1:0] rs;
      logic [reg_bits-1:0] rt;
      logic [15:0]         imm16;
    } i;
  } inst_t;

endpackage

`default_nettype wire

// ==== source/stage_link_if.sv ====
// ---------------------------------------------------------
// Links between neighboring stages, one instruction each
// ---------------------------------------------------------
`default_nettype none

interface fd_link_if;
  import proc_pkg::*;

  logic            val;
  inst_t           inst;
  logic [xlen-1:0] pc;
  logic            stall;   // D is holding its instruction

  modport fetch  (output val, inst, pc, input  stall);
  modport decode (input  val, inst, pc, output stall);
endinterface

interface dx_link_if;
  import proc_pkg::*;

  logic                val;
  logic [3:0]          alu_fn;
  logic [xlen-1:0]     op_a;
  logic [xlen-1:0]     op_b;
  logic [1:0]          br_type;
  logic [xlen-1:0]     br_target;
  logic                rf_wen;
  logic [reg_bits-1:0] rf_waddr;
  logic                to_mngr;

  // Back from X
  logic                stall;
  logic                x_wen;    // Valid X instruction that writes
  logic [reg_bits-1:0] x_waddr;

  modport decode (
    output val, alu_fn, op_a, op_b, br_type, br_target, rf_wen, rf_waddr, to_mngr,
    input  stall, x_wen, x_waddr
  );
  modport execute (
    input  val, alu_fn, op_a, op_b, br_type, br_target, rf_wen, rf_waddr, to_mngr,
    output stall, x_wen, x_waddr
  );
endinterface

`default_nettype wire

// ==== source/fetch_stage.sv ====
// ---------------------------------------------------------
// PC is a byte address and wraps over imem_words words
// Program memory may be written at any time
// ---------------------------------------------------------
`default_nettype none

module fetch_stage #(
  parameter int imem_words = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic                         prog_wen,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [proc_pkg::xlen-1:0]    prog_data,
  input  logic                         br_taken,
  input  logic [proc_pkg::xlen-1:0]    br_target,
  fd_link_if.fetch                     fd
);
  import proc_pkg::*;

  localparam int addr_bits = $clog2(imem_words);

  logic [xlen-1:0] imem [imem_words];
  logic [xlen-1:0] pc;
  logic            val_f;

  always_ff @(posedge clk) begin
    if (prog_wen) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // ---------------------------------------------------------
  // PC and F valid bit
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= '0;
      val_f <= 1'b0;
    end else if (start) begin
      pc    <= '0;
      val_f <= 1'b1;
    end else if (br_taken) begin
      pc    <= br_target;        // Target is fetched on the next cycle
    end else if (fd.val && !fd.stall) begin
      pc    <= pc + xlen'(4);
    end
  end

  assign fd.val  = val_f && !br_taken;  // Wrong-path fetch never reaches D
  assign fd.inst = imem[pc[addr_bits+1:2]];
  assign fd.pc   = pc;

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
// ---------------------------------------------------------
// No bypassing; RAW hazards stall until W has written
// Unknown encodings leave D as bubbles
// ---------------------------------------------------------
`default_nettype none

module decode_stage (
  input  logic                          clk,
  input  logic                          reset,
  fd_link_if.decode                     fd,
  dx_link_if.decode                     dx,
  input  logic                          br_taken,
  input  logic                          rf_we,
  input  logic [proc_pkg::reg_bits-1:0] rf_waddr,
  input  logic [proc_pkg::xlen-1:0]     rf_wdata,
  input  logic                          from_mngr_val,
  input  logic [proc_pkg::xlen-1:0]     from_mngr_msg,
  output logic                          from_mngr_rdy
);
  import proc_pkg::*;

  localparam logic n = 1'b0;
  localparam logic y = 1'b1;

  logic            val_d;
  inst_t           inst_d;
  logic [xlen-1:0] pc_d;
  logic            stall_d;

  always_ff @(posedge clk) begin
    if (reset || br_taken) begin
      val_d <= 1'b0;               // Squash on redirect
    end else if (!stall_d) begin
      val_d <= fd.val;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      inst_d <= fd.inst;
      pc_d   <= fd.pc;
    end
  end

  // ---------------------------------------------------------
  // Decode table
  // ---------------------------------------------------------

  logic                inst_val;
  logic [1:0]          br_type_d;
  logic                a_shamt;     // Operand A from shamt field
  logic                rs_en;
  logic [1:0]          bm_sel;
  logic                rt_en;
  logic [3:0]          alu_fn_d;
  logic                rf_wen_d;
  logic [reg_bits-1:0] rf_waddr_d;
  logic                to_mngr_d;
  logic                from_mngr_d;

  task automatic cs(
    input logic                c_val,
    input logic [1:0]          c_br,
    input logic                c_ash,
    input logic                c_rs_en,
    input logic [1:0]          c_bm,
    input logic                c_rt_en,
    input logic [3:0]          c_alu,
    input logic                c_wen,
    input logic [reg_bits-1:0] c_waddr,
    input logic                c_to_mngr,
    input logic                c_from_mngr
  );
    inst_val    = c_val;
    br_type_d   = c_br;
    a_shamt     = c_ash;
    rs_en       = c_rs_en;
    bm_sel      = c_bm;
    rt_en       = c_rt_en;
    alu_fn_d    = c_alu;
    rf_wen_d    = c_wen;
    rf_waddr_d  = c_waddr;
    to_mngr_d   = c_to_mngr;
    from_mngr_d = c_from_mngr;
  endtask

  logic [reg_bits-1:0] rd;
  logic [reg_bits-1:0] rt;

  assign rd = inst_d.r.rd;
  assign rt = inst_d.i.rt;

  always_comb begin
    //  val br       ash rs bm       rt alu      wen wa    tm fm
    cs( n,  br_none, n,  n, bm_reg,  n, alu_cp1, n,  5'd0, n, n );
    case (inst_d.r.opcode)
      op_special: begin
        case (inst_d.r.func)
          fn_addu: cs( y, br_none, n, y, bm_reg, y, alu_add, y, rd, n, n );
          fn_subu: cs( y, br_none, n, y, bm_reg, y, alu_sub, y, rd, n, n );
          fn_and:  cs( y, br_none, n, y, bm_reg, y, alu_and, y, rd, n, n );
          fn_or:   cs( y, br_none, n, y, bm_reg, y, alu_or,  y, rd, n, n );
          fn_xor:  cs( y, br_none, n, y, bm_reg, y, alu_xor, y, rd, n, n );
          fn_nor:  cs( y, br_none, n, y, bm_reg, y, alu_nor, y, rd, n, n );
          fn_slt:  cs( y, br_none, n, y, bm_reg, y, alu_lts, y, rd, n, n );
          fn_sltu: cs( y, br_none, n, y, bm_reg, y, alu_ltu, y, rd, n, n );
          fn_sll:  cs( y, br_none, y, n, bm_reg, y, alu_sll, y, rd, n, n );
          fn_srl:  cs( y, br_none, y, n, bm_reg, y, alu_srl, y, rd, n, n );
          fn_sra:  cs( y, br_none, y, n, bm_reg, y, alu_sra, y, rd, n, n );
          default: ;
        endcase
      end
      op_addiu: cs( y, br_none, n, y, bm_si,  n, alu_add, y, rt,   n, n );
      op_slti:  cs( y, br_none, n, y, bm_si,  n, alu_lts, y, rt,   n, n );
      op_sltiu: cs( y, br_none, n, y, bm_si,  n, alu_ltu, y, rt,   n, n );
      op_andi:  cs( y, br_none, n, y, bm_zi,  n, alu_and, y, rt,   n, n );
      op_ori:   cs( y, br_none, n, y, bm_zi,  n, alu_or,  y, rt,   n, n );
      op_xori:  cs( y, br_none, n, y, bm_zi,  n, alu_xor, y, rt,   n, n );
      op_lui:   cs( y, br_none, n, n, bm_zi,  n, alu_lui, y, rt,   n, n );
      op_beq:   cs( y, br_eq,   n, y, bm_reg, y, alu_cp1, n, 5'd0, n, n );
      op_bne:   cs( y, br_ne,   n, y, bm_reg, y, alu_cp1, n, 5'd0, n, n );
      op_cop0: begin
        if (inst_d.r.rs == cop0_mf) begin
          cs( y, br_none, n, n, bm_mngr, n, alu_cp1, y, rt,   n, y );
        end else if (inst_d.r.rs == cop0_mt) begin
          cs( y, br_none, n, n, bm_reg,  y, alu_cp1, n, 5'd0, y, n );
        end
      end
      default: ;
    endcase
  end

  // ---------------------------------------------------------
  // Register file and operands
  // ---------------------------------------------------------

  logic [xlen-1:0] rf [32];
  logic [xlen-1:0] rs_data;
  logic [xlen-1:0] rt_data;
  logic [xlen-1:0] imm_sext;

  always_ff @(posedge clk) begin
    if (rf_we && rf_waddr != '0) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  assign rs_data  = (inst_d.r.rs == '0) ? '0 : rf[inst_d.r.rs];
  assign rt_data  = (inst_d.r.rt == '0) ? '0 : rf[inst_d.r.rt];
  assign imm_sext = {{16{inst_d.i.imm16[15]}}, inst_d.i.imm16};

  always_comb begin
    case (bm_sel)
      bm_si:   dx.op_b = imm_sext;
      bm_zi:   dx.op_b = {16'b0, inst_d.i.imm16};
      bm_mngr: dx.op_b = from_mngr_msg;
      default: dx.op_b = rt_data;
    endcase
  end

  assign dx.op_a = a_shamt ? xlen'(inst_d.r.shamt) : rs_data;

  // ---------------------------------------------------------
  // Stalls
  // ---------------------------------------------------------

  logic hazard_rs;
  logic hazard_rt;
  logic mngr_stall;

  // Producer still in X, or in W and not yet written
  assign hazard_rs = rs_en && (inst_d.r.rs != '0) &&
                     ((dx.x_wen && inst_d.r.rs == dx.x_waddr) ||
                      (rf_we && inst_d.r.rs == rf_waddr));
  assign hazard_rt = rt_en && (inst_d.r.rt != '0) &&
                     ((dx.x_wen && inst_d.r.rt == dx.x_waddr) ||
                      (rf_we && inst_d.r.rt == rf_waddr));

  assign mngr_stall = from_mngr_d && !from_mngr_val;
  assign stall_d    = val_d && (hazard_rs || hazard_rt || mngr_stall || dx.stall);
  assign fd.stall   = stall_d;

  // Message is taken only on the cycle mfc0 leaves D
  assign from_mngr_rdy = val_d && from_mngr_d && !stall_d && !br_taken;

  assign dx.val       = val_d && inst_val && !stall_d && !br_taken;
  assign dx.alu_fn    = alu_fn_d;
  assign dx.br_type   = br_type_d;
  assign dx.br_target = pc_d + xlen'(4) + (imm_sext << 2);
  assign dx.rf_wen    = rf_wen_d;
  assign dx.rf_waddr  = rf_waddr_d;
  assign dx.to_mngr   = to_mngr_d;

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
// ---------------------------------------------------------
// Branches resolve here and redirect F at the same edge
// ---------------------------------------------------------
`default_nettype none

module execute_stage (
  input  logic                          clk,
  input  logic                          reset,
  dx_link_if.execute                    dx,
  output logic                          br_taken,
  output logic [proc_pkg::xlen-1:0]     br_target,
  output logic                          w_val,
  output logic [proc_pkg::xlen-1:0]     w_result,
  output logic                          w_rf_wen,
  output logic [proc_pkg::reg_bits-1:0] w_rf_waddr,
  output logic                          w_to_mngr,
  input  logic                          w_stall
);
  import proc_pkg::*;

  logic                x_val;
  logic [3:0]          x_alu_fn;
  logic [xlen-1:0]     x_op_a;
  logic [xlen-1:0]     x_op_b;
  logic [1:0]          x_br_type;
  logic [xlen-1:0]     x_br_target;
  logic                x_rf_wen;
  logic [reg_bits-1:0] x_rf_waddr;
  logic                x_to_mngr;
  logic                x_stall;
  logic [xlen-1:0]     alu_out;
  logic                op_eq;

  always_ff @(posedge clk) begin
    if (reset) begin
      x_val     <= 1'b0;
      x_br_type <= br_none;
      x_rf_wen  <= 1'b0;
      x_to_mngr <= 1'b0;
    end else if (!x_stall) begin
      x_val     <= dx.val;
      x_br_type <= dx.br_type;
      x_rf_wen  <= dx.rf_wen;
      x_to_mngr <= dx.to_mngr;
    end
  end

  always_ff @(posedge clk) begin
    if (!x_stall) begin
      x_alu_fn    <= dx.alu_fn;
      x_op_a      <= dx.op_a;
      x_op_b      <= dx.op_b;
      x_br_target <= dx.br_target;
      x_rf_waddr  <= dx.rf_waddr;
    end
  end

  assign x_stall    = x_val && w_stall;
  assign dx.stall   = x_stall;
  assign dx.x_wen   = x_val && x_rf_wen;
  assign dx.x_waddr = x_rf_waddr;

  // ---------------------------------------------------------
  // ALU and branch compare
  // ---------------------------------------------------------

  always_comb begin
    case (x_alu_fn)
      alu_add: alu_out = x_op_a + x_op_b;
      alu_sub: alu_out = x_op_a - x_op_b;
      alu_and: alu_out = x_op_a & x_op_b;
      alu_or:  alu_out = x_op_a | x_op_b;
      alu_xor: alu_out = x_op_a ^ x_op_b;
      alu_nor: alu_out = ~(x_op_a | x_op_b);
      alu_lts: alu_out = xlen'($signed(x_op_a) < $signed(x_op_b));
      alu_ltu: alu_out = xlen'(x_op_a < x_op_b);
      alu_sll: alu_out = x_op_b << x_op_a[reg_bits-1:0];   // Shamt in A
      alu_srl: alu_out = x_op_b >> x_op_a[reg_bits-1:0];
      alu_sra: alu_out = $signed(x_op_b) >>> x_op_a[reg_bits-1:0];
      alu_lui: alu_out = x_op_b << 16;
      default: alu_out = x_op_b;                           // cp1
    endcase
  end

  assign op_eq = (x_op_a == x_op_b);

  // Held branch redirects once it leaves X
  assign br_taken  = x_val && !x_stall &&
                     ((x_br_type == br_eq && op_eq) || (x_br_type == br_ne && !op_eq));
  assign br_target = x_br_target;

  // ---------------------------------------------------------
  // X to W register
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      w_val     <= 1'b0;
      w_rf_wen  <= 1'b0;
      w_to_mngr <= 1'b0;
    end else if (!w_stall) begin
      w_val     <= x_val;
      w_rf_wen  <= x_rf_wen;
      w_to_mngr <= x_to_mngr;
    end
  end

  always_ff @(posedge clk) begin
    if (!w_stall) begin
      w_result   <= alu_out;
      w_rf_waddr <= x_rf_waddr;
    end
  end

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
// ---------------------------------------------------------
// Only mtc0 can stall W, waiting on to_mngr_rdy
// ---------------------------------------------------------
`default_nettype none

module writeback_stage (
  input  logic                          w_val,
  input  logic [proc_pkg::xlen-1:0]     w_result,
  input  logic                          w_rf_wen,
  input  logic [proc_pkg::reg_bits-1:0] w_rf_waddr,
  input  logic                          w_to_mngr,
  output logic                          w_stall,
  output logic                          rf_we,
  output logic [proc_pkg::reg_bits-1:0] rf_waddr,
  output logic [proc_pkg::xlen-1:0]     rf_wdata,
  output logic                          to_mngr_val,
  output logic [proc_pkg::xlen-1:0]     to_mngr_msg,
  input  logic                          to_mngr_rdy
);

  logic send;

  // Register write port
  assign rf_we    = w_val && w_rf_wen;
  assign rf_waddr = w_rf_waddr;
  assign rf_wdata = w_result;

  // To-manager stream
  assign send        = w_val && w_to_mngr;
  assign to_mngr_val = send;
  assign to_mngr_msg = w_result;   // mtc0 value passed by the ALU
  assign w_stall     = send && !to_mngr_rdy;

endmodule

`default_nettype wire

// ==== source/tiny_proc.sv ====
// ---------------------------------------------------------
// Four-stage F D X W core; load program, then pulse start
// Manager streams transfer when val and rdy are both high
// ---------------------------------------------------------
`default_nettype none

module tiny_proc #(
  parameter int imem_words = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          prog_wen,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [proc_pkg::xlen-1:0]     prog_data,
  input  logic                          from_mngr_val,
  output logic                          from_mngr_rdy,
  input  logic [proc_pkg::xlen-1:0]     from_mngr_msg,
  output logic                          to_mngr_val,
  input  logic                          to_mngr_rdy,
  output logic [proc_pkg::xlen-1:0]     to_mngr_msg
);
  import proc_pkg::*;

  fd_link_if fd ();
  dx_link_if dx ();

  // Redirect from X
  logic                br_taken;
  logic [xlen-1:0]     br_target;

  // X to W
  logic                w_val;
  logic [xlen-1:0]     w_result;
  logic                w_rf_wen;
  logic [reg_bits-1:0] w_rf_waddr;
  logic                w_to_mngr;
  logic                w_stall;

  // Register write port
  logic                rf_we;
  logic [reg_bits-1:0] rf_waddr;
  logic [xlen-1:0]     rf_wdata;

  fetch_stage #(
    .imem_words (imem_words)
  ) fetch (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .prog_wen   (prog_wen),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .br_taken   (br_taken),
    .br_target  (br_target),
    .fd         (fd.fetch)
  );

  decode_stage decode (
    .clk           (clk),
    .reset         (reset),
    .fd            (fd.decode),
    .dx            (dx.decode),
    .br_taken      (br_taken),
    .rf_we         (rf_we),
    .rf_waddr      (rf_waddr),
    .rf_wdata      (rf_wdata),
    .from_mngr_val (from_mngr_val),
    .from_mngr_msg (from_mngr_msg),
    .from_mngr_rdy (from_mngr_rdy)
  );

  execute_stage execute (
    .clk        (clk),
    .reset      (reset),
    .dx         (dx.execute),
    .br_taken   (br_taken),
    .br_target  (br_target),
    .w_val      (w_val),
    .w_result   (w_result),
    .w_rf_wen   (w_rf_wen),
    .w_rf_waddr (w_rf_waddr),
    .w_to_mngr  (w_to_mngr),
    .w_stall    (w_stall)
  );

  writeback_stage writeback (
    .w_val       (w_val),
    .w_result    (w_result),
    .w_rf_wen    (w_rf_wen),
    .w_rf_waddr  (w_rf_waddr),
    .w_to_mngr   (w_to_mngr),
    .w_stall     (w_stall),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .to_mngr_val (to_mngr_val),
    .to_mngr_msg (to_mngr_msg),
    .to_mngr_rdy (to_mngr_rdy)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_isa_model.svh ====
// ------------------------------------------------------------
// Program generator and ISA interpreter for tiny_proc_tb
// Program must fit imem_depth words; registers r0..r7 only
// ------------------------------------------------------------
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int          imem_depth = 64;
localparam int          prog_len   = 53;   // 8 + 16*2 + 4*3 + 1
localparam int          n_from     = 8;
localparam int          n_random   = 16;
localparam int          n_branch   = 4;
localparam int          max_msgs   = 64;
localparam logic [31:0] seed       = 32'ha8cf;

localparam logic [5:0] r_funcs [11] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                                        fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
localparam logic [5:0] i_ops [7] = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori,
                                     op_xori, op_lui};

logic [31:0] rng_state;
logic [31:0] prog [imem_depth];
logic [31:0] from_msgs [n_from];
logic [31:0] exp_msgs [max_msgs];
int          exp_count;

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift(rng_state);
  return rng_state;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] func, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] shamt);
  inst_t w;
  w         = '0;
  w.r.rs    = rs;
  w.r.rt    = rt;
  w.r.rd    = rd;
  w.r.shamt = shamt;
  w.r.func  = func;     // Opcode stays special
  return w;
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] opcode, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
  inst_t w;
  w.i.opcode = opcode;
  w.i.rs     = rs;
  w.i.rt     = rt;
  w.i.imm16  = imm;
  return w;
endfunction

function automatic logic [31:0] enc_mtc0(input logic [4:0] rt);
  return enc_i(op_cop0, cop0_mt, rt, 16'h0);
endfunction

// ------------------------------------------------------------
// Program: mfc0 prologue, random ops, branch blocks, self-loop
// ------------------------------------------------------------
function automatic void build_program();
  int          pc;
  int          k;
  int          kind;
  logic [31:0] r;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  rng_state = seed;
  pc = 0;
  for (k = 0; k < n_from; k++) begin
    from_msgs[k] = next_rand();
  end
  for (k = 1; k < n_from; k++) begin
    prog[pc] = enc_i(op_cop0, cop0_mf, 5'(k), 16'h0);
    pc++;
  end
  prog[pc] = enc_i(op_cop0, cop0_mf, 5'd0, 16'h0);   // Write to r0 is lost
  pc++;
  for (k = 0; k < n_random; k++) begin
    r    = next_rand();
    rs   = {2'b0, r[2:0]};
    rt   = {2'b0, r[5:3]};
    rd   = {2'b0, r[8:6]};
    kind = int'(r[13:9]) % 18;
    if (kind < 8) begin
      prog[pc] = enc_r(r_funcs[kind], rs, rt, rd, 5'd0);
    end else if (kind < 11) begin
      prog[pc] = enc_r(r_funcs[kind], 5'd0, rt, rd, r[18:14]);
    end else begin
      prog[pc] = enc_i(i_ops[kind-11], rs, rd, r[31:16]);   // rd used as I dest
    end
    prog[pc+1] = enc_mtc0(rd);
    pc += 2;
  end
  for (k = 0; k < n_branch; k++) begin
    r  = next_rand();
    rs = {2'b0, r[2:0]};
    rt = r[3] ? rs : {2'b0, r[6:4]};
    prog[pc]   = enc_i(r[7] ? op_bne : op_beq, rs, rt, 16'd1);
    prog[pc+1] = enc_mtc0({2'b0, r[10:8]});   // Skipped when taken
    prog[pc+2] = enc_mtc0(rs);
    pc += 3;
  end
  prog[pc] = enc_i(op_beq, 5'd0, 5'd0, 16'hffff);
  pc++;
  for (k = pc; k < imem_depth; k++) begin
    prog[k] = enc_i(op_ori, 5'd0, 5'd0, 16'(k));
  end
endfunction

// Sequential interpreter; fills exp_msgs with mtc0 values
function automatic void run_reference();
  logic [31:0] regs [32];
  inst_t       w;
  int          pc;
  int          fi;
  int          steps;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] sext;
  logic [31:0] zext;
  logic        wr;
  logic [4:0]  dst;
  logic        done;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  pc = 0;
  fi = 0;
  steps = 0;
  done = 1'b0;
  exp_count = 0;
  while (!done && steps < 1000) begin
    w    = prog[pc % imem_depth];
    a    = regs[w.r.rs];
    b    = regs[w.r.rt];
    sext = {{16{w.i.imm16[15]}}, w.i.imm16};
    zext = {16'h0, w.i.imm16};
    wr   = 1'b1;
    dst  = w.i.rt;
    res  = '0;
    case (w.r.opcode)
      op_special: begin
        dst = w.r.rd;
        case (w.r.func)
          fn_addu: res = a + b;
          fn_subu: res = a - b;
          fn_and:  res = a & b;
          fn_or:   res = a | b;
          fn_xor:  res = a ^ b;
          fn_nor:  res = ~(a | b);
          fn_slt:  res = {31'b0, $signed(a) < $signed(b)};
          fn_sltu: res = {31'b0, a < b};
          fn_sll:  res = b << w.r.shamt;
          fn_srl:  res = b >> w.r.shamt;
          fn_sra:  res = $signed(b) >>> w.r.shamt;
          default: wr = 1'b0;
        endcase
      end
      op_addiu: res = a + sext;
      op_slti:  res = {31'b0, $signed(a) < $signed(sext)};
      op_sltiu: res = {31'b0, a < sext};
      op_andi:  res = a & zext;
      op_ori:   res = a | zext;
      op_xori:  res = a ^ zext;
      op_lui:   res = {w.i.imm16, 16'h0};
      op_beq, op_bne: begin
        wr = 1'b0;
        if ((a == b) == (w.r.opcode == op_beq)) begin
          if (sext == 32'hffff_ffff) begin
            done = 1'b1;    // Branch to itself ends the program
          end
          pc = pc + int'(sext);
        end
      end
      op_cop0: begin
        if (w.r.rs == cop0_mf) begin
          res = from_msgs[fi];
          fi++;
        end else begin
          wr = 1'b0;
          exp_msgs[exp_count] = b;
          exp_count++;
        end
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
      regs[dst] = res;
    end
    pc++;
    steps++;
  end
endfunction

`endif

// ==== testbench/tiny_proc_tb.sv ====
// ------------------------------------------------------------
// Random program against the reference interpreter
// Manager streams get random gaps and back-pressure
// ------------------------------------------------------------
`default_nettype none

module tiny_proc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import proc_pkg::*;

  `include "tb_isa_model.svh"

  localparam int clk_period      = 8;
  localparam int watchdog_cycles = prog_len * 40 + imem_depth + 200;

  logic        clk;
  logic        reset;
  logic        start;
  logic        prog_wen;
  logic [5:0]  prog_addr;
  logic [31:0] prog_data;
  logic        from_mngr_val;
  logic        from_mngr_rdy;
  logic [31:0] from_mngr_msg;
  logic        to_mngr_val;
  logic        to_mngr_rdy;
  logic [31:0] to_mngr_msg;
  int          received;

  tiny_proc #(
    .imem_words (imem_depth)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .prog_wen      (prog_wen),
    .prog_addr     (prog_addr),
    .prog_data     (prog_data),
    .from_mngr_val (from_mngr_val),
    .from_mngr_rdy (from_mngr_rdy),
    .from_mngr_msg (from_mngr_msg),
    .to_mngr_val   (to_mngr_val),
    .to_mngr_rdy   (to_mngr_rdy),
    .to_mngr_msg   (to_mngr_msg)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    reset         = 1'b1;
    start         = 1'b0;
    prog_wen      = 1'b0;
    prog_addr     = '0;
    prog_data     = '0;
    from_mngr_val = 1'b0;
    from_mngr_msg = '0;
    to_mngr_rdy   = 1'b0;
    received      = 0;
    build_program();
    run_reference();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int k = 0; k < imem_depth; k++) begin
      prog_wen  = 1'b1;
      prog_addr = 6'(k);
      prog_data = prog[k];
      @(negedge clk);
    end
    prog_wen = 1'b0;
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait (received == exp_count);
    repeat (20) @(negedge clk);   // Catch stray extra messages
    $display("Simulation completed successfully");
    $finish;
  end

  // From-manager source with random gaps
  initial begin : drive_from_mngr
    int          idx;
    logic        fire;
    logic [31:0] gap_state;
    idx       = 0;
    fire      = 1'b0;
    gap_state = seed ^ 32'h1;
    forever begin
      @(negedge clk);
      if (fire) begin
        idx++;
      end
      gap_state     = xorshift(gap_state);
      from_mngr_val = !reset && (idx < n_from) && (gap_state[1:0] != 2'b00);
      from_mngr_msg = (idx < n_from) ? from_msgs[idx] : 32'h0;
      #1;
      // mfc0 waits in D until a message is offered
      assert (from_mngr_val || !from_mngr_rdy) else begin
        $display("FAIL at %0t: from_mngr_rdy expected 0 actual %b",
                 $time, from_mngr_rdy);
        $display("Simulation failed");
        $fatal(1, "ready without valid");
      end
      fire = from_mngr_val && from_mngr_rdy;   // Transfers at the next rising edge
    end
  end

  // To-manager sink with random ready
  initial begin : drive_to_mngr_rdy
    logic [31:0] rdy_state;
    rdy_state = seed ^ 32'h2;
    forever begin
      @(negedge clk);
      rdy_state   = xorshift(rdy_state);
      to_mngr_rdy = !reset && (rdy_state[2:1] != 2'b00);
    end
  end

  // ------------------------------------------------------------
  // Compare each to-manager transfer with the model
  // ------------------------------------------------------------
  initial begin : compare_messages
    forever begin
      @(negedge clk);
      #2;
      if (to_mngr_val && to_mngr_rdy) begin
        assert (received < exp_count) else begin
          $display("DUT sent an extra message %h at time %0t", to_mngr_msg, $time);
          $display("Simulation failed");
          $fatal(1, "extra message");
        end
        assert (to_mngr_msg === exp_msgs[received]) else begin
          $display("FAIL at %0t: to_mngr_msg expected %h actual %h",
                   $time, exp_msgs[received], to_mngr_msg);
          $display("Simulation failed");
          $fatal(1, "message mismatch");
        end
        received++;
      end
    end
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("Timeout: only %0d of %0d expected messages were received",
             received, exp_count);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== tiny_proc.f ====
+incdir+testbench
source/proc_pkg.sv
source/stage_link_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/tiny_proc.sv
testbench/tiny_proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile tiny_proc_tb with Verilator and run it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tiny_proc.f --top-module tiny_proc_tb -o tiny_proc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tiny_proc_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
